/* logic/rram_pkg.sv */
`default_nettype none

package rram_pkg;

	localparam int ARRAY_LINES = 16;

	typedef enum logic [3:0] {
		OP_HALT  = 4'd0,
		OP_WRITE = 4'd1,
		OP_READ  = 4'd2
	} op_e;

	typedef struct packed {
		logic [3:0]  opcode;
		logic [18:0] filler;
		logic        data;    // 1 = SET, 0 = RESET
		logic [3:0]  row;
		logic [3:0]  col;
	} instr_t;

	typedef enum logic {
		CMD_WRITE,
		CMD_READ
	} cmd_kind_e;

	typedef struct packed {
		cmd_kind_e  kind;
		logic [3:0] row;
		logic [3:0] col;
		logic       data;
	} cmd_t;

	typedef logic [ARRAY_LINES-1:0] sense_t;

	typedef struct packed {
		logic                   en_wl;
		logic                   en_bl;
		logic                   en_sl;
		logic                   pre;
		logic                   saen;
		logic [ARRAY_LINES-1:0] wl0;
		logic [ARRAY_LINES-1:0] wl1;
		logic [ARRAY_LINES-1:0] bl0;
		logic [ARRAY_LINES-1:0] bl1;
		logic [ARRAY_LINES-1:0] sl0;
		logic [ARRAY_LINES-1:0] sl1;
	} drive_t;

	typedef struct packed {
		logic        we;
		logic [5:0]  addr;
		logic [31:0] wdata;
	} host_wr_t;

	////////////////////////////////////////////////////////////
	// Line codes, {bit of the 0 vector, bit of the 1 vector}
	////////////////////////////////////////////////////////////
	localparam logic [1:0] LC_GND      = 2'b11;
	localparam logic [1:0] LC_WL_WRITE = 2'b01;
	localparam logic [1:0] LC_WL_READ  = 2'b00;
	localparam logic [1:0] LC_BL_READ  = 2'b00;
	localparam logic [1:0] LC_BL_SET   = 2'b00;
	localparam logic [1:0] LC_BL_RESET = 2'b11;
	localparam logic [1:0] LC_SL_RESET = 2'b01;

	// Pins at rest: precharge on, everything else off and grounded
	localparam drive_t DRIVE_IDLE = '{
		en_wl: 1'b0,
		en_bl: 1'b0,
		en_sl: 1'b0,
		pre:   1'b1,
		saen:  1'b0,
		wl0:   '1,
		wl1:   '1,
		bl0:   '1,
		bl1:   '1,
		sl0:   '1,
		sl1:   '1
	};

endpackage

`default_nettype wire

/* logic/prog_store.sv */
`default_nettype none
`timescale 1ns/100ps

module prog_store import rram_pkg::*; #(
	parameter int PROG_DEPTH = 64
) (
	input  logic     clk,
	input  logic     rst,
	input  host_wr_t host_wr,
	input  logic     run,
	input  logic     fetch_req,
	output instr_t   instr,
	output logic     instr_valid
);

	localparam int AW = $clog2(PROG_DEPTH);

	instr_t         mem [PROG_DEPTH];
	logic [AW-1:0]  ptr;

	// Host port and fetch port share the clock
	always_ff @(posedge clk) begin
		if (host_wr.we)
			mem[host_wr.addr[AW-1:0]] <= instr_t'(host_wr.wdata);
		if (fetch_req)
			instr <= mem[ptr];
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ptr <= '0;
			instr_valid <= 1'b0;
		end else begin
			if (run)
				ptr <= '0;              // New run starts at word 0
			else if (fetch_req)
				ptr <= ptr + 1'b1;
			instr_valid <= fetch_req && !run;
		end
	end

endmodule

`default_nettype wire

/* logic/rram_decode.sv */
`default_nettype none
`timescale 1ns/100ps

module rram_decode import rram_pkg::*; #(
	parameter int CMD_DEPTH = 2
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   run,
	input  instr_t instr,
	input  logic   instr_valid,
	output logic   fetch_req,
	output cmd_t   cmd,
	output logic   cmd_valid,
	input  logic   credit_ret,
	output logic   done
);

	localparam int CW = $clog2(CMD_DEPTH + 1);

	typedef enum logic [1:0] {
		DS_IDLE,
		DS_RUN,
		DS_HALT
	} dec_state_e;

	dec_state_e    state;
	logic [CW-1:0] credits;
	logic          held_valid;   // Decoded command waiting for a credit
	cmd_t          held_cmd;
	logic          send;

	assign send = held_valid && (credits != '0);
	assign cmd_valid = send;
	assign cmd = held_cmd;

	// One fetch in flight at most, and only with a credit in hand
	assign fetch_req = (state == DS_RUN) && !instr_valid &&
		(!held_valid || send) && (credits != '0);

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			held_cmd.kind <= (instr.opcode == OP_READ) ? CMD_READ : CMD_WRITE;
			held_cmd.row <= instr.row;
			held_cmd.col <= instr.col;
			held_cmd.data <= instr.data;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			credits <= CW'(CMD_DEPTH);
		else
			credits <= credits - CW'(send) + CW'(credit_ret);
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= DS_IDLE;
			held_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			if (send)
				held_valid <= 1'b0;
			if (run) begin
				state <= DS_RUN;
				held_valid <= 1'b0;
				done <= 1'b0;
			end else if (state == DS_RUN && instr_valid) begin
				case (op_e'(instr.opcode))
					OP_HALT:  state <= DS_HALT;
					OP_WRITE: held_valid <= 1'b1;
					OP_READ:  held_valid <= 1'b1;
					default:  ;                     // Unknown opcode, skip
				endcase
			end else if (state == DS_HALT && credits == CW'(CMD_DEPTH)) begin
				state <= DS_IDLE;   // Execute has drained
				done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/rram_execute.sv */
`default_nettype none
`timescale 1ns/100ps

module rram_execute import rram_pkg::*; #(
	parameter int CMD_DEPTH = 2
) (
	input  logic   clk,
	input  logic   rst,
	input  cmd_t   cmd,
	input  logic   cmd_valid,
	output logic   credit_ret,
	output drive_t drv,
	input  sense_t csa,
	output sense_t sample,
	output logic   sample_valid
);

	localparam int PW = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int CW = $clog2(CMD_DEPTH + 1);

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_P0,
		PH_P1,
		PH_P2
	} phase_e;

	phase_e        state;
	cmd_t          q [CMD_DEPTH];
	cmd_t          cur;
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          pop;

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
		return (p == PW'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// Next command starts right after P2
	assign pop = (state == PH_IDLE || state == PH_P2) && (count != '0);

	assign credit_ret = (state == PH_P2);
	assign sample_valid = (state == PH_P2) && (cur.kind == CMD_READ);
	assign sample = csa;

	////////////////////////////////////////////////////////////
	// Command queue
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (cmd_valid)
			q[wr_ptr] <= cmd;
		if (pop)
			cur <= q[rd_ptr];
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			state <= PH_IDLE;
		end else begin
			if (cmd_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CW'(cmd_valid) - CW'(pop);
			case (state)
				PH_P0:   state <= PH_P1;
				PH_P1:   state <= PH_P2;
				default: state <= pop ? PH_P0 : PH_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Pin drive, settings of a phase reach the pins one cycle on
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			drv <= DRIVE_IDLE;
		end else begin
			case (state)
				PH_P0: if (cur.kind == CMD_READ) begin
					drv.pre <= 1'b0;
					drv.saen <= 1'b1;
					for (int i = 0; i < ARRAY_LINES; i++) begin
						{drv.wl0[i], drv.wl1[i]} <= (4'(i) == cur.row) ? LC_WL_READ : LC_GND;
						{drv.bl0[i], drv.bl1[i]} <= LC_BL_READ;
						{drv.sl0[i], drv.sl1[i]} <= LC_GND;
					end
				end else begin
					drv.en_wl <= 1'b1;
					drv.en_bl <= 1'b1;
					drv.en_sl <= 1'b1;
				end
				PH_P1: if (cur.kind == CMD_READ) begin
					drv.pre <= 1'b1;
					drv.en_wl <= 1'b1;
					drv.en_bl <= 1'b1;
				end else begin
					for (int i = 0; i < ARRAY_LINES; i++) begin
						{drv.wl0[i], drv.wl1[i]} <= (4'(i) == cur.row) ? LC_WL_WRITE : LC_GND;
						if (4'(i) == cur.col) begin
							{drv.bl0[i], drv.bl1[i]} <= cur.data ? LC_BL_SET : LC_BL_RESET;
							{drv.sl0[i], drv.sl1[i]} <= cur.data ? LC_GND : LC_SL_RESET;
						end else begin
							{drv.bl0[i], drv.bl1[i]} <= LC_GND;
							{drv.sl0[i], drv.sl1[i]} <= LC_GND;
						end
					end
				end
				PH_P2: drv <= DRIVE_IDLE;   // Release and ground
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/rram_result.sv */
`default_nettype none
`timescale 1ns/100ps

module rram_result import rram_pkg::*; #(
	parameter int RESULT_DEPTH = 16
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       run,
	input  sense_t     sample,
	input  logic       sample_valid,
	input  logic [3:0] res_addr,
	output sense_t     res_data,
	output logic [4:0] result_count
);

	localparam int AW = $clog2(RESULT_DEPTH);

	sense_t     mem [RESULT_DEPTH];
	logic [4:0] idx;
	logic       wr_en;

	// Samples past the end are dropped
	assign wr_en = sample_valid && (idx < 5'(RESULT_DEPTH));
	assign result_count = idx;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[idx[AW-1:0]] <= sample;
		res_data <= mem[res_addr];      // Registered host read
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			idx <= '0;
		else if (run)
			idx <= '0;
		else if (wr_en)
			idx <= idx + 1'b1;
	end

endmodule

`default_nettype wire

/* logic/rram_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

module rram_ctrl import rram_pkg::*; #(
	parameter int PROG_DEPTH   = 64,
	parameter int CMD_DEPTH    = 2,
	parameter int RESULT_DEPTH = 16
) (
	input  logic       clk,
	input  logic       rst,
	input  host_wr_t   host_wr,
	input  logic       run,
	input  logic [3:0] res_addr,
	output sense_t     res_data,
	output logic [4:0] result_count,
	output logic       done,
	input  sense_t     csa,
	output drive_t     drv
);

	instr_t instr;
	logic   instr_valid;
	logic   fetch_req;
	cmd_t   cmd;
	logic   cmd_valid;
	logic   credit_ret;
	sense_t sample;
	logic   sample_valid;

	prog_store #(.PROG_DEPTH(PROG_DEPTH)) prog_store_i (
		.clk(clk),
		.rst(rst),
		.host_wr(host_wr),
		.run(run),
		.fetch_req(fetch_req),
		.instr(instr),
		.instr_valid(instr_valid)
	);

	rram_decode #(.CMD_DEPTH(CMD_DEPTH)) rram_decode_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.instr(instr),
		.instr_valid(instr_valid),
		.fetch_req(fetch_req),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.credit_ret(credit_ret),
		.done(done)
	);

	// Queue depth matches the credits so a sent command always fits
	rram_execute #(.CMD_DEPTH(CMD_DEPTH)) rram_execute_i (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.credit_ret(credit_ret),
		.drv(drv),
		.csa(csa),
		.sample(sample),
		.sample_valid(sample_valid)
	);

	rram_result #(.RESULT_DEPTH(RESULT_DEPTH)) rram_result_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.sample(sample),
		.sample_valid(sample_valid),
		.res_addr(res_addr),
		.res_data(res_data),
		.result_count(result_count)
	);

endmodule

`default_nettype wire

/* sim/rram_ctrl_chk.sv */
`default_nettype none
`timescale 1ns/100ps

module rram_ctrl_chk import rram_pkg::*; #(
	parameter int CMD_DEPTH = 2,
	parameter bit PINS      = 1'b1
) (
	input logic       clk,
	input logic       rst,
	input logic [7:0] level,       // Credits in decode, queue fill in execute
	input drive_t     drv,
	input logic       exec_idle,
	input logic       credit_ret
);

	int fails = 0;

	level_max: assert property (@(posedge clk) disable iff (!rst) level <= 8'(CMD_DEPTH))
		else begin
			fails++;
			$error("Level %0d above the limit of %0d", level, CMD_DEPTH);
		end

	credit_busy: assert property (@(posedge clk) disable iff (!rst) credit_ret |-> !exec_idle)
		else begin
			fails++;
			$error("Credit returned while execute is idle");
		end

	////////////////////////////////////////////////////////////
	// Pin protocol
	////////////////////////////////////////////////////////////
	if (PINS) begin : g_pins
		one_wl: assert property (@(posedge clk) disable iff (!rst)
			$countones(~(drv.wl0 & drv.wl1)) <= 1)
			else begin
				fails++;
				$error("More than one word line off ground");
			end

		saen_sl: assert property (@(posedge clk) disable iff (!rst) !(drv.saen && drv.en_sl))
			else begin
				fails++;
				$error("Sense amplifier enabled with source lines on");
			end
	end

endmodule

// Decode drives no array pins
bind rram_decode rram_ctrl_chk #(.CMD_DEPTH(CMD_DEPTH), .PINS(1'b0)) chk_i (
	.clk(clk),
	.rst(rst),
	.level(8'(credits)),
	.drv(DRIVE_IDLE),
	.exec_idle(credits == CW'(CMD_DEPTH)),   // All credits home, no command in execute
	.credit_ret(credit_ret)
);

bind rram_execute rram_ctrl_chk #(.CMD_DEPTH(CMD_DEPTH)) chk_i (
	.clk(clk),
	.rst(rst),
	.level(8'(count)),
	.drv(drv),
	.exec_idle(drv == DRIVE_IDLE),   // Idle execute leaves its pins at rest
	.credit_ret(credit_ret)
);

`default_nettype wire

/* sim/rram_ctrl_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module rram_ctrl_tb import rram_pkg::*; ();

	localparam int CMD_DEPTH  = 2;
	localparam int MAX_CYCLES = 600;   // Per run, far above the longest program

	logic       clk = 1'b0;
	logic       rst;
	host_wr_t   host_wr;
	logic       run;
	logic [3:0] res_addr;
	sense_t     res_data;
	logic [4:0] result_count;
	logic       done;
	sense_t     csa;
	drive_t     drv;

	int         errors;
	int         timeouts;
	int         assert_fails;
	sense_t     xbar [ARRAY_LINES];      // Model cells, bit index is the column
	sense_t     exp_row [ARRAY_LINES];   // Expected contents of each row
	instr_t     prog [$];
	logic [3:0] read_rows [$];           // Rows read by the current program, in order
	logic [7:0] set_cells [$];           // {row, col} of cells written with 1

	rram_ctrl #(
		.PROG_DEPTH(64),
		.CMD_DEPTH(CMD_DEPTH),
		.RESULT_DEPTH(16)
	) rram_ctrl_i (
		.clk(clk),
		.rst(rst),
		.host_wr(host_wr),
		.run(run),
		.res_addr(res_addr),
		.res_data(res_data),
		.result_count(result_count),
		.done(done),
		.csa(csa),
		.drv(drv)
	);

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Crossbar model
	////////////////////////////////////////////////////////////
	// Cells change while all enables are on and a row carries the write code
	always @(negedge clk) begin
		if (drv.en_wl && drv.en_bl && drv.en_sl) begin
			for (int r = 0; r < ARRAY_LINES; r++) begin
				for (int c = 0; c < ARRAY_LINES; c++) begin
					if ({drv.wl0[r], drv.wl1[r]} == 2'b01) begin
						if ({drv.bl0[c], drv.bl1[c]} == 2'b00)
							xbar[r][c] = 1'b1;
						else if ({drv.sl0[c], drv.sl1[c]} == 2'b01)
							xbar[r][c] = 1'b0;
					end
				end
			end
		end
	end

	always_comb begin
		csa = '0;
		if (drv.en_wl) begin
			for (int r = 0; r < ARRAY_LINES; r++) begin
				if ({drv.wl0[r], drv.wl1[r]} == 2'b00)
					csa = xbar[r];   // Sensed row
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers and compare tasks
	////////////////////////////////////////////////////////////
	function automatic drive_t idle_drive();
		drive_t d;
		d = '0;
		d.pre = 1'b1;
		d.wl0 = '1;
		d.wl1 = '1;
		d.bl0 = '1;
		d.bl1 = '1;
		d.sl0 = '1;
		d.sl1 = '1;
		return d;
	endfunction

	function automatic instr_t make_instr(input logic [3:0] opcode, input logic [3:0] row,
		input logic [3:0] col, input logic data);
		instr_t w;
		w = '0;
		w.opcode = opcode;
		w.row = row;
		w.col = col;
		w.data = data;
		return w;
	endfunction

	task automatic check_sense(input string name, input sense_t exp, input sense_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input logic [4:0] exp, input logic [4:0] act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_drive(input string name, input drive_t exp, input drive_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic load_prog();
		foreach (prog[i]) begin
			@(posedge clk);
			#1;
			host_wr.we = 1'b1;
			host_wr.addr = 6'(i);
			host_wr.wdata = prog[i];
		end
		@(posedge clk);
		#1 host_wr.we = 1'b0;
	endtask

	task automatic read_result(input int idx, output sense_t val);
		@(posedge clk);
		#1 res_addr = 4'(idx);
		@(posedge clk);
		#1 val = res_data;
	endtask

	// Start a run, wait for done and compare every read against the expected rows
	task automatic run_check(input string name);
		int     cycles;
		sense_t val;
		@(posedge clk);
		#1 run = 1'b1;
		@(posedge clk);
		#1 run = 1'b0;
		check_count({name, " cleared"}, 5'd0, result_count);
		check_flag({name, " done low"}, 1'b0, done);
		cycles = 0;
		while (!done && cycles < MAX_CYCLES) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!done) begin
			timeouts++;
			$display("%s: done did not rise within %0d cycles", name, MAX_CYCLES);
		end else begin
			check_drive({name, " idle"}, idle_drive(), drv);
			check_count({name, " count"}, 5'(read_rows.size()), result_count);
			foreach (read_rows[i]) begin
				read_result(i, val);
				check_sense($sformatf("%s read %0d", name, i), exp_row[read_rows[i]], val);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic reset_state();
		check_drive("reset drive", idle_drive(), drv);
		check_flag("reset done", 1'b0, done);
		check_count("reset count", 5'd0, result_count);
	endtask

	task automatic set_then_read();
		logic [3:0] r;
		logic [3:0] c;
		prog.delete();
		read_rows.delete();
		for (int i = 0; i < 4; i++) begin
			r = 4'($urandom);
			c = 4'($urandom);
			prog.push_back(make_instr(OP_WRITE, r, c, 1'b1));
			exp_row[r][c] = 1'b1;
			set_cells.push_back({r, c});
		end
		foreach (set_cells[i]) begin
			prog.push_back(make_instr(OP_READ, set_cells[i][7:4], 4'd0, 1'b0));
			read_rows.push_back(set_cells[i][7:4]);
		end
		prog.push_back(make_instr(OP_HALT, 4'd0, 4'd0, 1'b0));
		load_prog();
		run_check("set_then_read");
	endtask

	task automatic reset_then_read();
		prog.delete();
		read_rows.delete();
		foreach (set_cells[i]) begin
			prog.push_back(make_instr(OP_WRITE, set_cells[i][7:4], set_cells[i][3:0], 1'b0));
			exp_row[set_cells[i][7:4]][set_cells[i][3:0]] = 1'b0;
		end
		foreach (set_cells[i]) begin
			prog.push_back(make_instr(OP_READ, set_cells[i][7:4], 4'd0, 1'b0));
			read_rows.push_back(set_cells[i][7:4]);
		end
		prog.push_back(make_instr(OP_HALT, 4'd0, 4'd0, 1'b0));
		load_prog();
		run_check("reset_then_read");
	endtask

	task automatic burst_reads();
		logic [3:0] r;
		prog.delete();
		read_rows.delete();
		for (int i = 0; i < 3 * CMD_DEPTH; i++) begin
			r = 4'($urandom);
			prog.push_back(make_instr(OP_READ, r, 4'd0, 1'b0));
			read_rows.push_back(r);
		end
		prog.push_back(make_instr(OP_HALT, 4'd0, 4'd0, 1'b0));
		load_prog();
		run_check("burst_reads");
	endtask

	// Skipped and post-halt words would flip a cell if they ran
	task automatic halt_and_skip();
		logic [3:0] r0;
		logic [3:0] c0;
		logic [3:0] r1;
		logic [3:0] c1;
		r0 = 4'($urandom);
		c0 = 4'($urandom);
		r1 = 4'($urandom);
		c1 = 4'($urandom);
		prog.delete();
		read_rows.delete();
		prog.push_back(make_instr(4'hb, r0, c0, !exp_row[r0][c0]));
		prog.push_back(make_instr(OP_READ, r0, 4'd0, 1'b0));
		prog.push_back(make_instr(OP_READ, r1, 4'd0, 1'b0));
		prog.push_back(make_instr(OP_HALT, 4'd0, 4'd0, 1'b0));
		prog.push_back(make_instr(OP_WRITE, r1, c1, !exp_row[r1][c1]));
		prog.push_back(make_instr(OP_READ, r1, 4'd0, 1'b0));
		read_rows.push_back(r0);
		read_rows.push_back(r1);
		load_prog();
		run_check("halt_and_skip");
		run_check("rerun");   // Same program again from word 0
	endtask

	initial begin
		void'($urandom(65));
		errors = 0;
		timeouts = 0;
		rst = 1'b0;
		run = 1'b0;
		host_wr = '0;
		res_addr = '0;
		for (int r = 0; r < ARRAY_LINES; r++) begin
			xbar[r] = 16'($urandom);
			exp_row[r] = xbar[r];
		end
		repeat (2) @(posedge clk);
		#1 rst = 1'b1;

		reset_state();
		set_then_read();
		reset_then_read();
		burst_reads();
		halt_and_skip();

		assert_fails = rram_ctrl_i.rram_decode_i.chk_i.fails +
			rram_ctrl_i.rram_execute_i.chk_i.fails;
		$display("Errors: %0d compare, %0d assertion, %0d timeout",
			errors, assert_fails, timeouts);
		if (errors == 0 && assert_fails == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
logic/rram_pkg.sv
logic/prog_store.sv
logic/rram_decode.sv
logic/rram_execute.sv
logic/rram_result.sv
logic/rram_ctrl.sv
sim/rram_ctrl_chk.sv
sim/rram_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rram_ctrl_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
